/* common/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Datapath width of operands and results
`define CORE_DATA_W 32

// Register file size and address width
`define CORE_REG_N 16
`define CORE_REG_AW 4

// Stages in the multiply pipeline
`define CORE_MUL_DEPTH 5

`endif

/* common/core_pkg.sv */
`include "core_params.svh"

package core_pkg;

   // Decoded opcode as presented on the issue port
   typedef enum logic [2:0] {
      OP_ADD = 3'd0,
      OP_SUB = 3'd1,
      OP_AND = 3'd2,
      OP_OR  = 3'd3,
      OP_LI  = 3'd4, // Load immediate
      OP_MUL = 3'd5  // Goes down the multiply pipeline
   } op_e;

   // Result travelling from an execute unit to writeback
   typedef struct packed {
      logic                    valid;
      logic [`CORE_REG_AW-1:0] dst;  // Destination register
      logic [`CORE_DATA_W-1:0] data;
   } pipe_op_t;

endpackage

/* common/rf_read_if.sv */
`timescale 1ns/1ps
`include "core_params.svh"

// Two combinational read ports of the register file
interface rf_read_if;

   logic [`CORE_REG_AW-1:0] src1;
   logic [`CORE_REG_AW-1:0] src2;
   logic [`CORE_DATA_W-1:0] rdata1;
   logic [`CORE_DATA_W-1:0] rdata2;

   // Address side, owned by issue control
   modport ctrl (output src1, src2);

   // Register file answers the addresses
   modport rf (input src1, src2, output rdata1, rdata2);

   // Execute units only see operand data
   modport sink (input rdata1, rdata2);

endinterface

/* hw/hazard_ctrl.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module hazard_ctrl (
   input  logic                    clk,
   input  logic                    if_id_reset,
   input  logic                    issue_valid,
   input  core_pkg::op_e           issue_op,
   input  logic [`CORE_REG_AW-1:0] issue_dst,
   input  logic [`CORE_REG_AW-1:0] issue_src1,
   input  logic [`CORE_REG_AW-1:0] issue_src2,
   output logic                    issue_ready,
   output logic                    accept,
   rf_read_if.ctrl                 rd,
   input  logic                    wb_valid,
   input  logic [`CORE_REG_AW-1:0] wb_dst
);

   import core_pkg::*;

   logic [`CORE_REG_N-1:0]       pending_q;  // Write outstanding per register
   logic [`CORE_MUL_DEPTH-2:0]   mul_slot_q; // MULs in flight, by age
   logic                         is_mul;
   logic                         reg_conflict;
   logic                         slot_taken;

   // Operands are read in the issue cycle
   assign rd.src1 = issue_src1;
   assign rd.src2 = issue_src2;

   assign is_mul = (issue_op == OP_MUL);

   // RAW on either source, WAW on the destination
   assign reg_conflict = pending_q[issue_src1] | pending_q[issue_src2] |
                         pending_q[issue_dst];

   // A MUL four cycles old reaches writeback together with an ALU issued now
   assign slot_taken = ~is_mul & mul_slot_q[`CORE_MUL_DEPTH-2];

   assign issue_ready = ~reg_conflict & ~slot_taken;
   assign accept      = issue_valid & issue_ready;

   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         mul_slot_q <= '0;
      end else begin
         mul_slot_q <= {mul_slot_q[`CORE_MUL_DEPTH-3:0], accept & is_mul};
      end
   end

   // Scoreboard
   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         pending_q <= '0;
      end else begin
         if (wb_valid)
            pending_q[wb_dst] <= 1'b0;    // Write has landed
         if (accept)
            pending_q[issue_dst] <= 1'b1;
      end
   end

endmodule

/* hw/regfile.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module regfile (
   input  logic                    clk,
   input  logic                    if_id_reset,
   rf_read_if.rf                   rd,
   input  core_pkg::pipe_op_t      alu_res,
   input  core_pkg::pipe_op_t      mul_res,
   output logic                    wb_valid,
   output logic [`CORE_REG_AW-1:0] wb_dst,
   output logic [`CORE_DATA_W-1:0] wb_data,
   input  logic [`CORE_REG_AW-1:0] dbg_addr,
   output logic [`CORE_DATA_W-1:0] dbg_data
);

   import core_pkg::*;

   logic [`CORE_DATA_W-1:0] regs_q [`CORE_REG_N];
   pipe_op_t                sel;

   // Issue control keeps the two streams apart, so a plain priority mux will do
   always_comb begin
      if (mul_res.valid)
         sel = mul_res;
      else
         sel = alu_res;
   end

   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         for (int i = 0; i < `CORE_REG_N; i++)
            regs_q[i] <= '0;
         wb_valid <= 1'b0;
      end else begin
         wb_valid <= sel.valid;
         if (sel.valid)
            regs_q[sel.dst] <= sel.data;
      end
   end

   // Writeback report, qualified by wb_valid
   always_ff @(posedge clk) begin
      wb_dst  <= sel.dst;
      wb_data <= sel.data;
   end

   // Async reads
   assign rd.rdata1 = regs_q[rd.src1];
   assign rd.rdata2 = regs_q[rd.src2];
   assign dbg_data  = regs_q[dbg_addr]; // Debug peek

endmodule

/* hw/alu_stage.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module alu_stage (
   input  logic                    clk,
   input  logic                    if_id_reset,
   input  logic                    start,
   input  core_pkg::op_e           op,
   input  logic [`CORE_REG_AW-1:0] dst,
   input  logic [`CORE_DATA_W-1:0] imm,
   rf_read_if.sink                 rd,
   output core_pkg::pipe_op_t      res
);

   import core_pkg::*;

   logic [`CORE_DATA_W-1:0] result;
   logic                    valid_q;
   logic [`CORE_REG_AW-1:0] dst_q;
   logic [`CORE_DATA_W-1:0] data_q;

   // Results wrap at the data width
   always_comb begin
      case (op)
         OP_ADD:  result = rd.rdata1 + rd.rdata2;
         OP_SUB:  result = rd.rdata1 - rd.rdata2;
         OP_AND:  result = rd.rdata1 & rd.rdata2;
         OP_OR:   result = rd.rdata1 | rd.rdata2;
         OP_LI:   result = imm;
         default: result = '0; // MUL never starts here
      endcase
   end

   always_ff @(posedge clk) begin
      if (if_id_reset)
         valid_q <= 1'b0;
      else
         valid_q <= start;
   end

   // Execute register
   always_ff @(posedge clk) begin
      if (start) begin
         dst_q  <= dst;
         data_q <= result;
      end
   end

   assign res = '{valid: valid_q, dst: dst_q, data: data_q};

endmodule

/* mul/mul_pipe.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module mul_pipe (
   input  logic                    clk,
   input  logic                    if_id_reset,
   input  logic                    start,
   input  logic [`CORE_REG_AW-1:0] dst,
   rf_read_if.sink                 rd,
   output core_pkg::pipe_op_t      res
);

   localparam int NPP = 4;                 // Partial products
   localparam int CW  = `CORE_DATA_W / NPP; // Multiplier slice per product

   logic [`CORE_MUL_DEPTH-1:0] vld_q;
   logic [`CORE_REG_AW-1:0]    dst_q [`CORE_MUL_DEPTH];
   logic [`CORE_DATA_W-1:0]    pp_d [NPP];
   logic [`CORE_DATA_W-1:0]    s1_pp_q [NPP];
   logic [`CORE_DATA_W-1:0]    s2_acc_q;
   logic [`CORE_DATA_W-1:0]    s2_pp_q [2];
   logic [`CORE_DATA_W-1:0]    s3_acc_q;
   logic [`CORE_DATA_W-1:0]    s3_pp_q;
   logic [`CORE_DATA_W-1:0]    s4_acc_q;
   logic [`CORE_DATA_W-1:0]    s5_sum_q;

   // Only the low word of the product is kept, so each slice product
   // is truncated after its shift
   always_comb begin
      for (int j = 0; j < NPP; j++)
         pp_d[j] = (rd.rdata1 * rd.rdata2[j*CW +: CW]) << (j*CW);
   end

   // Valid bits and destination tags move one stage per cycle
   always_ff @(posedge clk) begin
      if (if_id_reset)
         vld_q <= '0;
      else
         vld_q <= {vld_q[`CORE_MUL_DEPTH-2:0], start};
   end

   always_ff @(posedge clk) begin
      dst_q[0] <= dst;
      for (int s = 1; s < `CORE_MUL_DEPTH; s++)
         dst_q[s] <= dst_q[s-1];
   end

   always_ff @(posedge clk) begin
      s1_pp_q <= pp_d;                         // Stage 1

      s2_acc_q   <= s1_pp_q[0] + s1_pp_q[1];   // Stage 2
      s2_pp_q[0] <= s1_pp_q[2];
      s2_pp_q[1] <= s1_pp_q[3];

      s3_acc_q <= s2_acc_q + s2_pp_q[0];       // Stage 3
      s3_pp_q  <= s2_pp_q[1];

      s4_acc_q <= s3_acc_q + s3_pp_q;          // Stage 4

      s5_sum_q <= s4_acc_q;                    // Final sum
   end

   assign res = '{valid: vld_q[`CORE_MUL_DEPTH-1],
                  dst:   dst_q[`CORE_MUL_DEPTH-1],
                  data:  s5_sum_q};

endmodule

/* hw/core_top.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module core_top (
   input  logic                    clk,
   input  logic                    if_id_reset,

   // Issue port
   input  logic                    issue_valid,
   output logic                    issue_ready,
   input  core_pkg::op_e           issue_op,
   input  logic [`CORE_REG_AW-1:0] issue_dst,
   input  logic [`CORE_REG_AW-1:0] issue_src1,
   input  logic [`CORE_REG_AW-1:0] issue_src2,
   input  logic [`CORE_DATA_W-1:0] issue_imm,

   // Writeback report
   output logic                    wb_valid,
   output logic [`CORE_REG_AW-1:0] wb_dst,
   output logic [`CORE_DATA_W-1:0] wb_data,

   input  logic [`CORE_REG_AW-1:0] dbg_addr,
   output logic [`CORE_DATA_W-1:0] dbg_data
);

   import core_pkg::*;

   rf_read_if rd_if ();

   logic     accept;
   logic     alu_start;
   logic     mul_start;
   pipe_op_t alu_res;
   pipe_op_t mul_res;

   // Steer an accepted op to its unit
   assign mul_start = accept & (issue_op == OP_MUL);
   assign alu_start = accept & (issue_op != OP_MUL);

   hazard_ctrl hazard_ctrl_i (
      .clk         (clk),
      .if_id_reset (if_id_reset),
      .issue_valid (issue_valid),
      .issue_op    (issue_op),
      .issue_dst   (issue_dst),
      .issue_src1  (issue_src1),
      .issue_src2  (issue_src2),
      .issue_ready (issue_ready),
      .accept      (accept),
      .rd          (rd_if.ctrl),
      .wb_valid    (wb_valid),
      .wb_dst      (wb_dst)
   );

   regfile regfile_i (
      .clk         (clk),
      .if_id_reset (if_id_reset),
      .rd          (rd_if.rf),
      .alu_res     (alu_res),
      .mul_res     (mul_res),
      .wb_valid    (wb_valid),
      .wb_dst      (wb_dst),
      .wb_data     (wb_data),
      .dbg_addr    (dbg_addr),
      .dbg_data    (dbg_data)
   );

   alu_stage alu_stage_i (
      .clk         (clk),
      .if_id_reset (if_id_reset),
      .start       (alu_start),
      .op          (issue_op),
      .dst         (issue_dst),
      .imm         (issue_imm),
      .rd          (rd_if.sink),
      .res         (alu_res)
   );

   mul_pipe mul_pipe_i (
      .clk         (clk),
      .if_id_reset (if_id_reset),
      .start       (mul_start),
      .dst         (issue_dst),
      .rd          (rd_if.sink),
      .res         (mul_res)
   );

endmodule

/* dv/core_chk.sv */
`timescale 1ns/1ps

module core_chk (
   input logic               clk,
   input logic               if_id_reset,
   input logic               issue_ready,
   input logic               accept,
   input logic               alu_start,
   input logic               mul_start,
   input core_pkg::pipe_op_t alu_res,
   input core_pkg::pipe_op_t mul_res,
   input logic               wb_valid
);

   int unsigned fail_cnt = 0;
   logic        seen_accept;  // Cleared by reset, set by the first acceptance

   always_ff @(posedge clk) begin
      if (if_id_reset)
         seen_accept <= 1'b0;
      else if (accept)
         seen_accept <= 1'b1;
   end

   a_idle_after_reset: assert property (@(posedge clk) disable iff (if_id_reset)
         !seen_accept |-> !wb_valid && issue_ready)
      else begin
         fail_cnt++;
         $error("Core not idle before the first acceptance");
      end

   a_alu_latency: assert property (@(posedge clk) disable iff (if_id_reset)
         alu_start |-> ##2 wb_valid)
      else begin
         fail_cnt++;
         $error("ALU result not written back 2 cycles after issue");
      end

   a_mul_latency: assert property (@(posedge clk) disable iff (if_id_reset)
         mul_start |-> ##6 wb_valid)
      else begin
         fail_cnt++;
         $error("MUL result not written back 6 cycles after issue");
      end

   // Back-to-back MULs come out back to back
   a_mul_stream: assert property (@(posedge clk) disable iff (if_id_reset)
         mul_start ##1 mul_start |-> ##5 (wb_valid ##1 wb_valid))
      else begin
         fail_cnt++;
         $error("Consecutive MULs lost their spacing");
      end

   a_single_result: assert property (@(posedge clk) disable iff (if_id_reset)
         !(alu_res.valid && mul_res.valid))
      else begin
         fail_cnt++;
         $error("ALU and MUL results reached writeback together");
      end

   a_wb_origin: assert property (@(posedge clk) disable iff (if_id_reset)
         wb_valid |-> $past(alu_start, 2) || $past(mul_start, 6))
      else begin
         fail_cnt++;
         $error("Writeback with no matching issue");
      end

endmodule

bind core_top core_chk core_chk_i (
   .clk         (clk),
   .if_id_reset (if_id_reset),
   .issue_ready (issue_ready),
   .accept      (accept),
   .alu_start   (alu_start),
   .mul_start   (mul_start),
   .alu_res     (alu_res),
   .mul_res     (mul_res),
   .wb_valid    (wb_valid)
);

/* dv/core_tb.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module core_tb;

   import core_pkg::*;

   localparam int N_RAND      = 300;
   localparam int N_MUL_B2B   = 8;
   localparam int N_OPS       = `CORE_REG_N + N_RAND + N_MUL_B2B;
   localparam int TIMEOUT_CYC = 10 * N_OPS + 200;

   // One expected writeback
   typedef struct {
      logic [`CORE_REG_AW-1:0] dst;
      logic [`CORE_DATA_W-1:0] data;
      int unsigned             cyc;  // Cycle count at which wb_valid is due
   } wb_exp_t;

   logic                    clk;
   logic                    if_id_reset;
   logic                    issue_valid;
   logic                    issue_ready;
   op_e                     issue_op;
   logic [`CORE_REG_AW-1:0] issue_dst;
   logic [`CORE_REG_AW-1:0] issue_src1;
   logic [`CORE_REG_AW-1:0] issue_src2;
   logic [`CORE_DATA_W-1:0] issue_imm;
   logic                    wb_valid;
   logic [`CORE_REG_AW-1:0] wb_dst;
   logic [`CORE_DATA_W-1:0] wb_data;
   logic [`CORE_REG_AW-1:0] dbg_addr;
   logic [`CORE_DATA_W-1:0] dbg_data;

   // Shadow model
   logic [`CORE_DATA_W-1:0] model_regs [`CORE_REG_N];
   logic [`CORE_REG_N-1:0]  model_pend;
   wb_exp_t                 exp_q [$];
   int unsigned             cyc;
   logic [`CORE_REG_AW-1:0] recent [4]; // Last few destinations

   core_top core_top_i (
      .clk         (clk),
      .if_id_reset (if_id_reset),
      .issue_valid (issue_valid),
      .issue_ready (issue_ready),
      .issue_op    (issue_op),
      .issue_dst   (issue_dst),
      .issue_src1  (issue_src1),
      .issue_src2  (issue_src2),
      .issue_imm   (issue_imm),
      .wb_valid    (wb_valid),
      .wb_dst      (wb_dst),
      .wb_data     (wb_data),
      .dbg_addr    (dbg_addr),
      .dbg_data    (dbg_data)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string test, input logic [31:0] exp,
                                  input logic [31:0] act);
      abort_run($sformatf("[ERROR] %s: expected 0x%0h, actual 0x%0h", test, exp, act));
   endtask

   // Architectural result of one operation
   function automatic logic [`CORE_DATA_W-1:0] expected_result(
      input op_e op, input logic [`CORE_DATA_W-1:0] a, input logic [`CORE_DATA_W-1:0] b,
      input logic [`CORE_DATA_W-1:0] imm);
      case (op)
         OP_ADD:  return a + b;
         OP_SUB:  return a - b;
         OP_AND:  return a & b;
         OP_OR:   return a | b;
         OP_MUL:  return a * b; // Low word only
         default: return imm;
      endcase
   endfunction

   // Favour recent destinations so that RAW stalls happen often
   function automatic logic [`CORE_REG_AW-1:0] pick_src();
      if ($urandom_range(0, 1) == 0)
         return recent[$urandom_range(0, 3)];
      return $urandom_range(0, `CORE_REG_N-1);
   endfunction

   // Present one op and hold it until it is accepted
   task automatic send(input op_e op, input logic [`CORE_REG_AW-1:0] dst,
                       input logic [`CORE_REG_AW-1:0] s1, input logic [`CORE_REG_AW-1:0] s2,
                       input logic [`CORE_DATA_W-1:0] imm);
      issue_valid <= 1'b1;
      issue_op    <= op;
      issue_dst   <= dst;
      issue_src1  <= s1;
      issue_src2  <= s2;
      issue_imm   <= imm;
      do @(posedge clk); while (!issue_ready);
   endtask

   task automatic idle_until_drained();
      issue_valid <= 1'b0;
      do @(posedge clk); while (exp_q.size() != 0);
   endtask

   initial begin : stimulus
      op_e                     op;
      logic [`CORE_REG_AW-1:0] dst;
      logic [`CORE_REG_AW-1:0] s1;
      logic [`CORE_REG_AW-1:0] s2;
      void'($urandom(32'ha537_b48a));
      if_id_reset = 1'b1;
      issue_valid = 1'b0;
      issue_op    = OP_ADD;
      issue_dst   = '0;
      issue_src1  = '0;
      issue_src2  = '0;
      issue_imm   = '0;
      dbg_addr    = '0;
      for (int k = 0; k < 4; k++)
         recent[k] = k;
      repeat (10) @(posedge clk);
      if_id_reset <= 1'b0;
      @(posedge clk);

      for (int i = 0; i < `CORE_REG_N; i++)
         send(OP_LI, i, i, i, $urandom);

      for (int n = 0; n < N_RAND; n++) begin
         if ($urandom_range(0, 2) == 0)
            op = OP_MUL;            // About a third
         else
            op = op_e'($urandom_range(0, 4));
         dst = $urandom_range(0, `CORE_REG_N-1);
         s1  = pick_src();
         s2  = pick_src();
         send(op, dst, s1, s2, $urandom);
         recent[n % 4] = dst;
      end
      idle_until_drained();

      // Independent MULs, one per cycle
      for (int i = 0; i < N_MUL_B2B; i++)
         send(OP_MUL, 8 + i, i, (i + 3) % 8, '0);
      idle_until_drained();

      for (int a = 0; a < `CORE_REG_N; a++) begin
         dbg_addr <= a;
         @(posedge clk);
         assert (dbg_data === model_regs[a])
            else report_mismatch($sformatf("dbg_read r%0d", a), model_regs[a], dbg_data);
      end

      if (core_top_i.core_chk_i.fail_cnt != 0 || exp_q.size() != 0)
         abort_run("Assertion failures or outstanding results at the end of the run");
      else begin
         $display("Simulation finished: PASS");
         $finish;
      end
   end

   always @(posedge clk) begin : monitor
      wb_exp_t e;
      int      hit;
      logic    hazard;
      if (if_id_reset) begin
         cyc        = 0;
         model_pend = '0;
         for (int i = 0; i < `CORE_REG_N; i++)
            model_regs[i] = '0;
      end else begin
         cyc++;
         if (cyc > TIMEOUT_CYC)
            abort_run($sformatf("Timeout: run did not end within %0d cycles", TIMEOUT_CYC));
         if (core_top_i.core_chk_i.fail_cnt != 0)
            abort_run("A concurrent assertion in core_chk failed");

         if (issue_valid && issue_ready) begin
            hazard = model_pend[issue_src1] | model_pend[issue_src2] | model_pend[issue_dst];
            assert (!hazard) else report_mismatch("issue_ready on hazard", 32'd0, 32'd1);
            e.dst  = issue_dst;
            e.data = expected_result(issue_op, model_regs[issue_src1],
                                     model_regs[issue_src2], issue_imm);
            e.cyc  = cyc + ((issue_op == OP_MUL) ? 6 : 2);
            model_regs[issue_dst] = e.data;
            model_pend[issue_dst] = 1'b1;
            exp_q.push_back(e);
         end

         if (wb_valid) begin
            hit = -1;
            foreach (exp_q[k])
               if (exp_q[k].cyc == cyc)
                  hit = k;
            if (hit < 0) begin
               abort_run($sformatf("Writeback to r%0d at cycle %0d matches no accepted op",
                                   wb_dst, cyc));
            end else begin
               assert (wb_dst == exp_q[hit].dst)
                  else report_mismatch("wb_dst", exp_q[hit].dst, wb_dst);
               assert (wb_data == exp_q[hit].data)
                  else report_mismatch($sformatf("wb_data r%0d", wb_dst),
                                       exp_q[hit].data, wb_data);
               model_pend[wb_dst] = 1'b0;
               exp_q.delete(hit);
            end
         end

         foreach (exp_q[k])
            if (exp_q[k].cyc <= cyc)
               abort_run($sformatf("Missing writeback to r%0d due at cycle %0d",
                                   exp_q[k].dst, exp_q[k].cyc));
      end
   end

endmodule

/* core.f */
+incdir+common
common/core_pkg.sv
common/rf_read_if.sv
hw/hazard_ctrl.sv
hw/regfile.sv
hw/alu_stage.sv
mul/mul_pipe.sv
hw/core_top.sv
dv/core_chk.sv
dv/core_tb.sv
